// ==== design/memPkg.sv ====
`default_nettype none

package memPkg;

    // address, data and length widths
    typedef logic [31:0] addrT;
    typedef logic [7:0]  byteT;
    typedef logic [31:0] wordT;
    typedef logic [2:0]  lenT;
    typedef logic [1:0]  stageT;

    // what the accepted request is doing
    typedef enum logic [1:0] {
        kindIdle,
        kindFetch,
        kindLoad,
        kindStore
    } reqKindE;

    // accepted request, held by decode until finish
    typedef struct packed {
        reqKindE kind;
        addrT    addr;
        lenT     len;
        wordT    wdata;
    } memReqT;

    // one byte-wide RAM access
    typedef struct packed {
        logic write;
        addrT addr;
        byteT wdata;
    } ramCmdT;

    // issued byte, delayed to line up with the RAM read data
    typedef struct packed {
        reqKindE kind;
        stageT   stage;
        logic    last;
    } stepT;

endpackage

`default_nettype wire

// ==== design/memReqDecode.sv ====
`timescale 1ns/1ns
`default_nettype none

module memReqDecode (
    input  logic           clk,
    input  logic           rst,
    input  logic           i_rdy,
    input  logic           i_ioBufferFull,
    input  logic           i_ifEn,
    input  memPkg::addrT   i_ifAddr,
    input  logic           i_dcEn,
    input  logic           i_dcStore,
    input  memPkg::lenT    i_dcLen,
    input  memPkg::addrT   i_dcAddr,
    input  memPkg::wordT   i_dcData,
    input  logic           i_finish,
    output memPkg::memReqT o_req,
    output logic           o_start,
    output logic           o_advance,
    output logic           o_ifWait,
    output logic           o_dcWait
);

    typedef enum logic {
        stateIdle,
        stateBusy
    } stateE;

    stateE          state;
    memPkg::memReqT nextReq;
    logic           accept;
    logic           busyData;
    logic           busyFetch;

    // the whole controller freezes on either stall input
    assign o_advance = i_rdy && !i_ioBufferFull;

    assign accept  = (state == stateIdle) && o_advance && (i_dcEn || i_ifEn);
    assign o_start = accept;

    // data port wins when both are asking
    always_comb begin
        if (i_dcEn) begin
            nextReq.kind  = i_dcStore ? memPkg::kindStore : memPkg::kindLoad;
            nextReq.addr  = i_dcAddr;
            nextReq.len   = i_dcLen;
            nextReq.wdata = i_dcData;
        end else begin
            // instructions are always four bytes
            nextReq.kind  = memPkg::kindFetch;
            nextReq.addr  = i_ifAddr;
            nextReq.len   = 3'd4;
            nextReq.wdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= stateIdle;
            o_req.kind <= memPkg::kindIdle;
        end else begin
            case (state)
                stateIdle: begin
                    if (accept) begin
                        state <= stateBusy;
                        o_req <= nextReq;
                    end
                end
                stateBusy: begin
                    if (i_finish) begin
                        state      <= stateIdle;
                        o_req.kind <= memPkg::kindIdle;
                    end
                end
                default: begin
                    state <= stateIdle;
                end
            endcase
        end
    end

    assign busyData  = (state == stateBusy) &&
                       (o_req.kind == memPkg::kindLoad || o_req.kind == memPkg::kindStore);
    assign busyFetch = (state == stateBusy) && (o_req.kind == memPkg::kindFetch);

    // who is stuck behind whom
    assign o_ifWait = busyData && i_ifEn;
    assign o_dcWait = busyFetch && i_dcEn;

endmodule

`default_nettype wire

// ==== design/memByteSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module memByteSequencer (
    input  logic           clk,
    input  logic           rst,
    input  memPkg::memReqT i_req,
    input  logic           i_start,
    input  logic           i_advance,
    output memPkg::ramCmdT o_ramCmd,
    output memPkg::stepT   o_step,
    output logic           o_stepValid
);

    logic          active;
    memPkg::stageT stage;
    logic          isLast;
    logic          isStore;

    // final byte when stage + 1 equals the request length
    assign isLast  = ({1'b0, stage} == (i_req.len - 3'd1));
    assign isStore = (i_req.kind == memPkg::kindStore);

    // stage counter, one byte per advancing cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            stage  <= '0;
        end else if (i_advance) begin
            if (i_start) begin
                active <= 1'b1;
                stage  <= '0;
            end else if (active) begin
                if (isLast) begin
                    active <= 1'b0;
                    stage  <= '0;
                end else begin
                    stage <= stage + 2'd1;
                end
            end
        end
    end

    // RAM command for the current stage
    always_comb begin
        o_ramCmd.write = active && isStore;
        o_ramCmd.addr  = i_req.addr + memPkg::addrT'(stage);
        if (active && isStore) begin
            // little-endian byte lane
            o_ramCmd.wdata = i_req.wdata[stage * 8 +: 8];
        end else begin
            o_ramCmd.wdata = '0;
        end
    end

    // step goes out one cycle later, together with the read byte
    always_ff @(posedge clk) begin
        if (rst) begin
            o_stepValid <= 1'b0;
        end else if (i_advance) begin
            o_stepValid <= active;
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance && active) begin
            o_step.kind  <= i_req.kind;
            o_step.stage <= stage;
            o_step.last  <= isLast;
        end
    end

endmodule

`default_nettype wire

// ==== design/memRespAssembler.sv ====
`timescale 1ns/1ns
`default_nettype none

module memRespAssembler (
    input  logic         clk,
    input  logic         rst,
    input  logic         i_advance,
    input  memPkg::stepT i_step,
    input  logic         i_stepValid,
    input  memPkg::byteT i_ramData,
    output logic         o_ifDone,
    output memPkg::wordT o_ifInst,
    output logic         o_dcDone,
    output memPkg::wordT o_dcData,
    output logic         o_finish
);

    memPkg::wordT partial;
    memPkg::wordT merged;
    logic         fire;
    logic         isFetch;
    logic         isLoad;
    logic         isStore;

    // a step only counts on an advancing cycle
    assign fire    = i_stepValid && i_advance;
    assign isFetch = (i_step.kind == memPkg::kindFetch);
    assign isLoad  = (i_step.kind == memPkg::kindLoad);
    assign isStore = (i_step.kind == memPkg::kindStore);

    // bytes before the last one collect here, cleared once the access ends
    always_ff @(posedge clk) begin
        if (rst) begin
            partial <= '0;
        end else if (fire) begin
            if (i_step.last) begin
                partial <= '0;
            end else if (!isStore) begin
                partial[i_step.stage * 8 +: 8] <= i_ramData;
            end
        end
    end

    // bytes above the last stage are still zero, so short loads come out zero-extended
    always_comb begin
        merged = partial;
        merged[i_step.stage * 8 +: 8] = i_ramData;
    end

    assign o_ifDone = fire && i_step.last && isFetch;
    assign o_dcDone = fire && i_step.last && (isLoad || isStore);
    assign o_finish = o_ifDone || o_dcDone;

    always_comb begin
        o_ifInst = '0;
        o_dcData = '0;
        if (o_ifDone) begin
            o_ifInst = merged;
        end
        // store done carries no data
        if (o_dcDone && isLoad) begin
            o_dcData = merged;
        end
    end

endmodule

`default_nettype wire

// ==== design/byteRam.sv ====
`timescale 1ns/1ns
`default_nettype none

module byteRam #(
    parameter int RAM_ADDR_BITS = 12
) (
    input  logic           clk,
    input  logic           i_advance,
    input  memPkg::ramCmdT i_cmd,
    output memPkg::byteT   o_data
);

    localparam int DEPTH = 2 ** RAM_ADDR_BITS;

    memPkg::byteT             mem [DEPTH];
    logic [RAM_ADDR_BITS-1:0] index;

    // address wraps inside the RAM
    assign index = i_cmd.addr[RAM_ADDR_BITS-1:0];

    // everything holds while the controller is stalled
    always_ff @(posedge clk) begin
        if (i_advance) begin
            if (i_cmd.write) begin
                mem[index] <= i_cmd.wdata;
            end
            // read sees the old byte on a write cycle
            o_data <= mem[index];
        end
    end

endmodule

`default_nettype wire

// ==== design/memCtrlTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module memCtrlTop #(
    parameter int RAM_ADDR_BITS = 12
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         i_rdy,
    input  logic         i_ioBufferFull,
    input  logic         i_ifEn,
    input  memPkg::addrT i_ifAddr,
    output logic         o_ifDone,
    output memPkg::wordT o_ifInst,
    input  logic         i_dcEn,
    input  logic         i_dcStore,
    input  memPkg::lenT  i_dcLen,
    input  memPkg::addrT i_dcAddr,
    input  memPkg::wordT i_dcData,
    output logic         o_dcDone,
    output memPkg::wordT o_dcData,
    output logic         o_ifWait,
    output logic         o_dcWait
);

    memPkg::memReqT req;
    memPkg::ramCmdT ramCmd;
    memPkg::stepT   step;
    memPkg::byteT   ramData;
    logic           start;
    logic           advance;
    logic           stepValid;
    logic           finish;

    memReqDecode u_decode (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_ifEn         (i_ifEn),
        .i_ifAddr       (i_ifAddr),
        .i_dcEn         (i_dcEn),
        .i_dcStore      (i_dcStore),
        .i_dcLen        (i_dcLen),
        .i_dcAddr       (i_dcAddr),
        .i_dcData       (i_dcData),
        .i_finish       (finish),
        .o_req          (req),
        .o_start        (start),
        .o_advance      (advance),
        .o_ifWait       (o_ifWait),
        .o_dcWait       (o_dcWait)
    );

    memByteSequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .i_req       (req),
        .i_start     (start),
        .i_advance   (advance),
        .o_ramCmd    (ramCmd),
        .o_step      (step),
        .o_stepValid (stepValid)
    );

    // advance doubles as the RAM hold release
    byteRam #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) u_ram (
        .clk       (clk),
        .i_advance (advance),
        .i_cmd     (ramCmd),
        .o_data    (ramData)
    );

    memRespAssembler u_assembler (
        .clk         (clk),
        .rst         (rst),
        .i_advance   (advance),
        .i_step      (step),
        .i_stepValid (stepValid),
        .i_ramData   (ramData),
        .o_ifDone    (o_ifDone),
        .o_ifInst    (o_ifInst),
        .o_dcDone    (o_dcDone),
        .o_dcData    (o_dcData),
        .o_finish    (finish)
    );

endmodule

`default_nettype wire

// ==== testbench/memCtrl_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module memCtrlAssertions (
    input logic           clk,
    input logic           rst,
    input logic           i_advance,
    input memPkg::memReqT i_req,
    input memPkg::ramCmdT i_ramCmd,
    input logic           i_active,
    input memPkg::stageT  i_stage,
    input memPkg::stepT   i_step,
    input logic           i_stepValid
);

    int assertFails = 0;

    // only a store may strobe the RAM
    writeOnlyOnStore: assert property (@(posedge clk) disable iff (rst)
        i_ramCmd.write |-> (i_req.kind == memPkg::kindStore))
        else begin
            $error("RAM write strobe high for a request that is not a store");
            assertFails++;
        end

    // stage stays below the access length
    stageBelowLen: assert property (@(posedge clk) disable iff (rst)
        i_active |-> ({1'b0, i_stage} < i_req.len))
        else begin
            $error("byte stage reached the access length");
            assertFails++;
        end

    // a stalled cycle freezes the sequencer
    holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
        !i_advance |=> ($stable(i_active) && $stable(i_stage) &&
                        $stable(i_stepValid) && $stable(i_step)))
        else begin
            $error("sequencer state changed while advance was low");
            assertFails++;
        end

endmodule

bind memByteSequencer memCtrlAssertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .i_advance   (i_advance),
    .i_req       (i_req),
    .i_ramCmd    (o_ramCmd),
    .i_active    (active),
    .i_stage     (stage),
    .i_step      (o_step),
    .i_stepValid (o_stepValid)
);

`default_nettype wire

// ==== testbench/memCtrlTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module memCtrlTb;

    localparam int TIMEOUT_CYCLES = 200;

    logic         clk;
    logic         rst;
    logic         i_rdy;
    logic         i_ioBufferFull;
    logic         i_ifEn;
    memPkg::addrT i_ifAddr;
    logic         o_ifDone;
    memPkg::wordT o_ifInst;
    logic         i_dcEn;
    logic         i_dcStore;
    memPkg::lenT  i_dcLen;
    memPkg::addrT i_dcAddr;
    memPkg::wordT i_dcData;
    logic         o_dcDone;
    memPkg::wordT o_dcData;
    logic         o_ifWait;
    logic         o_dcWait;

    // reference copy of the 256-byte RAM
    memPkg::byteT model [256];
    int           errCount;
    int           testErrStart;
    int           passCount;
    int           failCount;

    memCtrlTop #(.RAM_ADDR_BITS(8)) i_dut (.*);

    always #50 clk = ~clk;

    function automatic memPkg::wordT modelRead(input memPkg::addrT addr, input int len);
        memPkg::wordT w;
        w = '0;
        for (int k = 0; k < len; k++) begin
            w[k * 8 +: 8] = model[(addr + k) & 32'hff];
        end
        return w;
    endfunction

    task automatic modelWrite(input memPkg::addrT addr, input int len, input memPkg::wordT data);
        for (int k = 0; k < len; k++) begin
            model[(addr + k) & 32'hff] = data[k * 8 +: 8];
        end
    endtask

    task automatic checkValue(input string testName, input memPkg::wordT expected,
                              input memPkg::wordT actual);
        assert (actual === expected)
        else begin
            $display("FAIL %s expected %h actual %h", testName, expected, actual);
            errCount++;
        end
    endtask

    task automatic finishTest(input string testName);
        if (errCount == testErrStart) begin
            passCount++;
            $display("test %s: ok", testName);
        end else begin
            failCount++;
            $display("test %s: %0d errors", testName, errCount - testErrStart);
        end
        testErrStart = errCount;
    endtask

    // one request on one port, optionally with random stall cycles
    task automatic runAccess(input string testName, input bit isFetch, input bit isStore,
                             input int len, input memPkg::addrT addr, input memPkg::wordT wdata,
                             input bit useStalls, output memPkg::wordT result);
        int cycles;
        int latency;
        int stalled;
        bit accepted;
        bit seenDone;
        bit adv;
        cycles   = 0;
        latency  = 0;
        stalled  = 0;
        accepted = 1'b0;
        seenDone = 1'b0;
        result   = '0;
        @(posedge clk);
        if (isFetch) begin
            i_ifEn   <= 1'b1;
            i_ifAddr <= addr;
        end else begin
            i_dcEn    <= 1'b1;
            i_dcStore <= isStore;
            i_dcLen   <= memPkg::lenT'(len);
            i_dcAddr  <= addr;
            i_dcData  <= wdata;
        end
        while (!seenDone && cycles < TIMEOUT_CYCLES) begin
            if (useStalls) begin
                i_rdy          <= ($urandom_range(3, 0) != 0);
                i_ioBufferFull <= ($urandom_range(4, 0) == 0);
            end
            @(negedge clk);
            adv = i_rdy && !i_ioBufferFull;
            if (accepted) begin
                latency++;
                if (!adv) begin
                    stalled++;
                end
            end
            if (isFetch ? o_ifDone : o_dcDone) begin
                seenDone = 1'b1;
                result   = isFetch ? o_ifInst : o_dcData;
            end
            // first advancing cycle with the enable up is the acceptance cycle
            if (!accepted && adv) begin
                accepted = 1'b1;
            end
            cycles++;
            @(posedge clk);
        end
        i_ifEn         <= 1'b0;
        i_dcEn         <= 1'b0;
        i_rdy          <= 1'b1;
        i_ioBufferFull <= 1'b0;
        if (!seenDone) begin
            $display("timeout: %s never raised its done pulse", testName);
            errCount++;
        end else begin
            checkValue({testName, " latency"}, len + 1 + stalled, latency);
        end
    endtask

    // both enables rise together, data must go first
    task automatic priorityTest(input string testName, input memPkg::addrT dAddr,
                                input memPkg::addrT fAddr);
        int           c;
        int           dcCycle;
        int           dcAgainCycle;
        int           ifCycle;
        bit           dcDoneNow;
        bit           ifDoneNow;
        memPkg::wordT dcRes;
        memPkg::wordT dcAgainRes;
        memPkg::wordT ifRes;
        c            = 0;
        dcCycle      = -1;
        dcAgainCycle = -1;
        ifCycle      = -1;
        dcRes        = '0;
        dcAgainRes   = '0;
        ifRes        = '0;
        @(posedge clk);
        i_dcEn    <= 1'b1;
        i_dcStore <= 1'b0;
        i_dcLen   <= 3'd4;
        i_dcAddr  <= dAddr;
        i_ifEn    <= 1'b1;
        i_ifAddr  <= fAddr;
        while (dcAgainCycle < 0 && c < TIMEOUT_CYCLES) begin
            @(negedge clk);
            // data access busy from cycle 1 up to its done in cycle 5
            checkValue({testName, " ifWait"}, (c >= 1 && c <= 5), o_ifWait);
            // second load raised in cycle 8 sits behind the fetch until cycle 11
            checkValue({testName, " dcWait"}, (c >= 8 && c <= 11), o_dcWait);
            dcDoneNow = o_dcDone;
            ifDoneNow = o_ifDone;
            if (dcDoneNow) begin
                if (dcCycle < 0) begin
                    dcCycle = c;
                    dcRes   = o_dcData;
                end else begin
                    dcAgainCycle = c;
                    dcAgainRes   = o_dcData;
                end
            end
            if (ifDoneNow) begin
                ifCycle = c;
                ifRes   = o_ifInst;
            end
            @(posedge clk);
            if (dcDoneNow) begin
                i_dcEn <= 1'b0;
            end
            if (ifDoneNow) begin
                i_ifEn <= 1'b0;
            end
            // same load again while the fetch is busy
            if (c == 7) begin
                i_dcEn <= 1'b1;
            end
            c++;
        end
        i_ifEn <= 1'b0;
        i_dcEn <= 1'b0;
        if (dcAgainCycle < 0) begin
            $display("timeout: the requests in %s never all finished", testName);
            errCount++;
        end else begin
            checkValue({testName, " data done cycle"}, 5, dcCycle);
            checkValue({testName, " fetch done cycle"}, 11, ifCycle);
            checkValue({testName, " second data done cycle"}, 17, dcAgainCycle);
            checkValue({testName, " data word"}, modelRead(dAddr, 4), dcRes);
            checkValue({testName, " fetch word"}, modelRead(fAddr, 4), ifRes);
            checkValue({testName, " second data word"}, modelRead(dAddr, 4), dcAgainRes);
        end
    endtask

    initial begin
        memPkg::wordT res;
        memPkg::addrT addr;
        memPkg::wordT data;
        int           len;
        int           kind;
        clk            = 1'b0;
        rst            = 1'b1;
        i_rdy          = 1'b1;
        i_ioBufferFull = 1'b0;
        i_ifEn         = 1'b0;
        i_ifAddr       = '0;
        i_dcEn         = 1'b0;
        i_dcStore      = 1'b0;
        i_dcLen        = '0;
        i_dcAddr       = '0;
        i_dcData       = '0;
        errCount       = 0;
        testErrStart   = 0;
        passCount      = 0;
        failCount      = 0;
        void'($urandom(32'h41c));

        // four reset cycles, then one more idle cycle
        for (int c = 0; c < 5; c++) begin
            @(posedge clk);
            if (c == 3) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            checkValue("reset flags", 0, {o_ifDone, o_dcDone, o_ifWait, o_dcWait});
            checkValue("reset ifInst", 0, o_ifInst);
            checkValue("reset dcData", 0, o_dcData);
        end
        finishTest("reset");

        for (int a = 0; a < 64; a++) begin
            data = $urandom();
            runAccess("preload store", 1'b0, 1'b1, 4, a * 4, data, 1'b0, res);
            checkValue("preload store data", 0, res);
            modelWrite(a * 4, 4, data);
        end
        finishTest("preload");

        repeat (8) begin
            addr = $urandom();
            runAccess("fetch", 1'b1, 1'b0, 4, addr, '0, 1'b0, res);
            checkValue("fetch word", modelRead(addr, 4), res);
        end
        finishTest("fetch");

        for (int i = 0; i < 3; i++) begin
            repeat (4) begin
                len  = 1 << i;
                addr = $urandom();
                runAccess($sformatf("load len %0d", len), 1'b0, 1'b0, len, addr, '0, 1'b0, res);
                checkValue($sformatf("load len %0d word", len), modelRead(addr, len), res);
            end
        end
        finishTest("loads");

        for (int i = 0; i < 3; i++) begin
            repeat (3) begin
                len  = 1 << i;
                addr = $urandom();
                data = $urandom();
                runAccess($sformatf("store len %0d", len), 1'b0, 1'b1, len, addr, data, 1'b0, res);
                checkValue($sformatf("store len %0d data", len), 0, res);
                modelWrite(addr, len, data);
                runAccess("readback load", 1'b0, 1'b0, 4, addr, '0, 1'b0, res);
                checkValue($sformatf("store len %0d readback", len), modelRead(addr, 4), res);
            end
        end
        finishTest("stores");

        repeat (3) begin
            priorityTest("priority", $urandom(), $urandom());
        end
        finishTest("priority");

        repeat (12) begin
            kind = $urandom_range(2, 0);
            len  = (kind == 0) ? 4 : (1 << $urandom_range(2, 0));
            addr = $urandom();
            data = $urandom();
            runAccess("stalled access", kind == 0, kind == 2, len, addr, data, 1'b1, res);
            if (kind == 2) begin
                checkValue("stalled store data", 0, res);
                modelWrite(addr, len, data);
                runAccess("stalled readback", 1'b0, 1'b0, 4, addr, '0, 1'b1, res);
                checkValue("stalled readback word", modelRead(addr, 4), res);
            end else begin
                checkValue("stalled read word", modelRead(addr, len), res);
            end
        end
        finishTest("stalls");

        $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 passCount, failCount, i_dut.u_sequencer.u_assertions.assertFails);
        if (failCount == 0 && i_dut.u_sequencer.u_assertions.assertFails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/memPkg.sv
design/memReqDecode.sv
design/memByteSequencer.sv
design/memRespAssembler.sv
design/byteRam.sv
design/memCtrlTop.sv
testbench/memCtrl_assertions.sv
testbench/memCtrlTb.sv
